// File: compute_core.f
hdl/datapath_pkg.sv
hdl/isa_pkg.sv
hdl/operation_if.sv
hdl/sequencer.sv
hdl/instruction_decoder.sv
hdl/execute_unit.sv
hdl/register_file.sv
hdl/compute_core.sv
testbench/compute_core_checker.sv
testbench/compute_core_tb.sv

// File: hdl/compute_core.sv
// Core top level; run is ignored while busy and program_write only takes effect while idle
`timescale 1ns/10ps

module compute_core #(
    parameter int PROGRAM_DEPTH = 64
) (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             run,
    input  logic                             program_write,
    input  logic [$clog2(PROGRAM_DEPTH)-1:0] program_address,
    input  isa_pkg::instruction_t            program_data,
    input  datapath_pkg::reg_index_t         debug_address,
    output datapath_pkg::word_t              debug_data,
    output logic                             done,
    output logic                             fault
);
    import isa_pkg::*;
    import datapath_pkg::*;

    logic         fetch_valid;
    instruction_t fetch_word;
    logic         halt_fetch;
    logic         end_strobe;
    logic         end_illegal;
    reg_index_t   read_address_a;
    reg_index_t   read_address_b;
    word_t        read_data_a;
    word_t        read_data_b;
    logic         write_strobe;
    reg_index_t   write_dest;
    word_t        write_data;

    operation_if operation ();

    ////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////

    sequencer #(
        .PROGRAM_DEPTH(PROGRAM_DEPTH)
    ) fetch (
        .clock(clock),
        .reset(reset),
        .run(run),
        .program_write(program_write),
        .program_address(program_address),
        .program_data(program_data),
        .halt_fetch(halt_fetch),
        .end_strobe(end_strobe),
        .end_illegal(end_illegal),
        .fetch_valid(fetch_valid),
        .fetch_word(fetch_word),
        .done(done),
        .fault(fault)
    );

    instruction_decoder decode (
        .clock(clock),
        .reset(reset),
        .fetch_valid(fetch_valid),
        .fetch_word(fetch_word),
        .halt_fetch(halt_fetch),
        .operation(operation.decoder)
    );

    execute_unit execute (
        .clock(clock),
        .reset(reset),
        .operation(operation.execute),
        .read_address_a(read_address_a),
        .read_address_b(read_address_b),
        .read_data_a(read_data_a),
        .read_data_b(read_data_b),
        .write_strobe(write_strobe),
        .write_dest(write_dest),
        .write_data(write_data),
        .end_strobe(end_strobe),
        .end_illegal(end_illegal)
    );

    // Writeback stage
    register_file result (
        .clock(clock),
        .reset(reset),
        .read_address_a(read_address_a),
        .read_address_b(read_address_b),
        .debug_address(debug_address),
        .read_data_a(read_data_a),
        .read_data_b(read_data_b),
        .debug_data(debug_data),
        .write_strobe(write_strobe),
        .write_dest(write_dest),
        .write_data(write_data)
    );

endmodule

// File: hdl/datapath_pkg.sv
// Data word and register numbering; word width and register count are tied to the instruction format
package datapath_pkg;

    ////////////////////////////////////////
    // Data word
    ////////////////////////////////////////

    localparam int WORD_WIDTH = 32;

    typedef logic [WORD_WIDTH-1:0] word_t;

    ////////////////////////////////////////
    // Register file
    ////////////////////////////////////////

    localparam int REGISTER_COUNT = 16;

    // Index width follows from the count
    localparam int REGISTER_INDEX_WIDTH = $clog2(REGISTER_COUNT);

    typedef logic [REGISTER_INDEX_WIDTH-1:0] reg_index_t;

endpackage

// File: hdl/execute_unit.sv
// Single-cycle ALU with one bypass level; relies on the decoder issuing at most one op per cycle
`timescale 1ns/10ps

module execute_unit (
    input  logic                     clock,
    input  logic                     reset,
    operation_if.execute             operation,
    output datapath_pkg::reg_index_t read_address_a,
    output datapath_pkg::reg_index_t read_address_b,
    input  datapath_pkg::word_t      read_data_a,
    input  datapath_pkg::word_t      read_data_b,
    output logic                     write_strobe,
    output datapath_pkg::reg_index_t write_dest,
    output datapath_pkg::word_t      write_data,
    output logic                     end_strobe,
    output logic                     end_illegal
);
    import isa_pkg::*;
    import datapath_pkg::*;

    word_t operand_a;
    word_t operand_b;
    word_t result;
    logic  writes_register;

    ////////////////////////////////////////
    // Operands
    ////////////////////////////////////////

    assign read_address_a = operation.source_a;
    assign read_address_b = operation.source_b;

    // Previous result is still in flight to the register file
    always_comb begin
        operand_a = read_data_a;
        if (write_strobe && write_dest == operation.source_a) begin
            operand_a = write_data;
        end
        if (operation.use_immediate) begin
            operand_b = operation.immediate;
        end else if (write_strobe && write_dest == operation.source_b) begin
            operand_b = write_data;
        end else begin
            operand_b = read_data_b;
        end
    end

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        case (operation.opcode)
            ADD, ADDI: result = operand_a + operand_b;
            SUB: result = operand_a - operand_b;
            AND: result = operand_a & operand_b;
            OR:  result = operand_a | operand_b;
            XOR: result = operand_a ^ operand_b;
            SHL: result = operand_a << operand_b[4:0];
            SHR: result = operand_a >> operand_b[4:0];
            SLT: result = {{(WORD_WIDTH - 1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            LDI: result = operand_b;
            default: result = '0;
        endcase
    end

    assign writes_register = operation.valid && operation.end_kind == END_NONE
                             && operation.opcode != NOP;

    always_ff @(posedge clock) begin
        if (reset) begin
            write_strobe <= 1'b0;
            end_strobe   <= 1'b0;
        end else begin
            write_strobe <= writes_register;
            end_strobe   <= operation.valid && operation.end_kind != END_NONE;
        end
    end

    always_ff @(posedge clock) begin
        write_dest  <= operation.dest;
        write_data  <= result;
        end_illegal <= operation.end_kind == END_ILLEGAL;
    end

endmodule

// File: hdl/instruction_decoder.sv
// Registered decode, one word per cycle; after an end marker, fetches are dropped until fetch idles
`timescale 1ns/10ps

module instruction_decoder (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  fetch_valid,
    input  isa_pkg::instruction_t fetch_word,
    output logic                  halt_fetch,
    operation_if.decoder          operation
);
    import isa_pkg::*;
    import datapath_pkg::*;

    opcode_t    fetched_opcode;
    logic [1:0] fetched_end;
    logic       fetched_use_immediate;
    word_t      fetched_immediate;
    logic       accept;
    // High from an end marker until the sequencer stops fetching
    logic       ignoring;

    always_comb begin
        fetched_opcode        = fetch_word.register_view.opcode;
        fetched_use_immediate = 1'b0;
        fetched_end           = END_NONE;
        case (fetched_opcode)
            NOP, ADD, SUB, AND, OR, XOR, SHL, SHR, SLT: fetched_end = END_NONE;
            ADDI, LDI: fetched_use_immediate = 1'b1;
            STOP: fetched_end = END_STOP;
            default: fetched_end = END_ILLEGAL;
        endcase
        fetched_immediate = {{(WORD_WIDTH - IMMEDIATE_WIDTH){
            fetch_word.immediate_view.immediate[IMMEDIATE_WIDTH-1]}},
            fetch_word.immediate_view.immediate};
    end

    assign accept = fetch_valid && !ignoring;

    always_ff @(posedge clock) begin
        if (reset) begin
            operation.valid <= 1'b0;
            halt_fetch      <= 1'b0;
            ignoring        <= 1'b0;
        end else begin
            operation.valid <= accept;
            halt_fetch      <= accept && fetched_end != END_NONE;
            if (accept && fetched_end != END_NONE) begin
                ignoring <= 1'b1;
            end else if (!fetch_valid) begin
                ignoring <= 1'b0;
            end
        end
    end

    // Operation payload, qualified by valid
    always_ff @(posedge clock) begin
        operation.opcode        <= fetched_opcode;
        operation.dest          <= fetch_word.register_view.dest;
        operation.source_a      <= fetch_word.register_view.source_a;
        operation.source_b      <= fetch_word.register_view.source_b;
        operation.immediate     <= fetched_immediate;
        operation.use_immediate <= fetched_use_immediate;
        operation.end_kind      <= fetched_end;
    end

endmodule

// File: hdl/isa_pkg.sv
// Instruction format for the core; opcode always in the top 5 bits, unlisted opcodes are illegal
package isa_pkg;

    ////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////

    typedef enum logic [4:0] {
        NOP  = 5'd0,
        ADD  = 5'd1,
        SUB  = 5'd2,
        AND  = 5'd3,
        OR   = 5'd4,
        XOR  = 5'd5,
        SHL  = 5'd6,
        SHR  = 5'd7,
        SLT  = 5'd8,
        ADDI = 5'd9,
        LDI  = 5'd10,
        STOP = 5'd31
    } opcode_t;

    localparam int IMMEDIATE_WIDTH = 19;

    // How an operation ends a program
    localparam logic [1:0] END_NONE    = 2'd0;
    localparam logic [1:0] END_STOP    = 2'd1;
    localparam logic [1:0] END_ILLEGAL = 2'd2;

    ////////////////////////////////////////
    // Instruction word
    ////////////////////////////////////////

    typedef union packed {
        struct packed {
            opcode_t                  opcode;
            datapath_pkg::reg_index_t dest;
            datapath_pkg::reg_index_t source_a;
            datapath_pkg::reg_index_t source_b;
            logic [14:0]              unused;
        } register_view;
        // ADDI and LDI only
        struct packed {
            opcode_t                      opcode;
            datapath_pkg::reg_index_t     dest;
            datapath_pkg::reg_index_t     source_a;
            logic [IMMEDIATE_WIDTH-1:0]   immediate;
        } immediate_view;
    } instruction_t;

endpackage

// File: hdl/operation_if.sv
// Decoded operation, one per cycle when valid; no back-pressure, the receiver must take it
`timescale 1ns/10ps

interface operation_if;
    import isa_pkg::*;
    import datapath_pkg::*;

    logic       valid;
    opcode_t    opcode;
    reg_index_t dest;
    reg_index_t source_a;
    reg_index_t source_b;
    // Already sign-extended to a full word
    word_t      immediate;
    logic       use_immediate;
    logic [1:0] end_kind;

    modport decoder (
        output valid, opcode, dest, source_a, source_b,
        output immediate, use_immediate, end_kind
    );

    modport execute (
        input valid, opcode, dest, source_a, source_b,
        input immediate, use_immediate, end_kind
    );

endinterface

// File: hdl/register_file.sv
// Sixteen registers, cleared by reset; reads are combinational and do not see a same-cycle write
`timescale 1ns/10ps

module register_file (
    input  logic                     clock,
    input  logic                     reset,
    input  datapath_pkg::reg_index_t read_address_a,
    input  datapath_pkg::reg_index_t read_address_b,
    input  datapath_pkg::reg_index_t debug_address,
    output datapath_pkg::word_t      read_data_a,
    output datapath_pkg::word_t      read_data_b,
    output datapath_pkg::word_t      debug_data,
    input  logic                     write_strobe,
    input  datapath_pkg::reg_index_t write_dest,
    input  datapath_pkg::word_t      write_data
);
    import datapath_pkg::*;

    word_t registers [REGISTER_COUNT];

    assign read_data_a = registers[read_address_a];
    assign read_data_b = registers[read_address_b];
    // Debug port for the host side
    assign debug_data  = registers[debug_address];

    always_ff @(posedge clock) begin
        if (reset) begin
            registers <= '{default: '0};
        end else if (write_strobe) begin
            registers[write_dest] <= write_data;
        end
    end

endmodule

// File: hdl/sequencer.sv
// Program store and fetch control; PROGRAM_DEPTH must be a power of two, loading only while idle
`timescale 1ns/10ps

module sequencer #(
    parameter int PROGRAM_DEPTH = 64
) (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             run,
    input  logic                             program_write,
    input  logic [$clog2(PROGRAM_DEPTH)-1:0] program_address,
    input  isa_pkg::instruction_t            program_data,
    input  logic                             halt_fetch,
    input  logic                             end_strobe,
    input  logic                             end_illegal,
    output logic                             fetch_valid,
    output isa_pkg::instruction_t            fetch_word,
    output logic                             done,
    output logic                             fault
);
    import isa_pkg::*;

    localparam int ADDRESS_WIDTH = $clog2(PROGRAM_DEPTH);
    localparam logic [ADDRESS_WIDTH-1:0] LAST_ADDRESS = ADDRESS_WIDTH'(PROGRAM_DEPTH - 1);

    localparam logic [1:0] IDLE     = 2'd0;
    localparam logic [1:0] FETCHING = 2'd1;
    localparam logic [1:0] DRAINING = 2'd2;

    instruction_t             program_store [PROGRAM_DEPTH];
    logic [ADDRESS_WIDTH-1:0] program_counter;
    logic [1:0]               state;
    // Set when fetching ran past the end with no stop in sight
    logic                     ran_off_end;
    logic [1:0]               drain_count;

    ////////////////////////////////////////
    // Program store
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (program_write && state == IDLE) begin
            program_store[program_address] <= program_data;
        end
        fetch_word <= program_store[program_counter];
    end

    ////////////////////////////////////////
    // Fetch and end control
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state           <= IDLE;
            program_counter <= '0;
            fetch_valid     <= 1'b0;
            done            <= 1'b0;
            fault           <= 1'b0;
            ran_off_end     <= 1'b0;
            drain_count     <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                FETCHING: begin
                    if (halt_fetch) begin
                        state       <= DRAINING;
                        fetch_valid <= 1'b0;
                    end else begin
                        fetch_valid     <= 1'b1;
                        program_counter <= program_counter + 1'b1;
                        if (program_counter == LAST_ADDRESS) begin
                            state       <= DRAINING;
                            ran_off_end <= 1'b1;
                            drain_count <= '0;
                        end
                    end
                end
                DRAINING: begin
                    fetch_valid <= 1'b0;
                    drain_count <= drain_count + 2'd1;
                    // A late stop from the last word still ends cleanly
                    if (halt_fetch) begin
                        ran_off_end <= 1'b0;
                    end
                    if (end_strobe) begin
                        state <= IDLE;
                        done  <= !end_illegal;
                        fault <= end_illegal;
                    end else if (ran_off_end && drain_count == 2'd2) begin
                        // Last word has been written by now
                        state <= IDLE;
                        fault <= 1'b1;
                    end
                end
                default: begin
                    fetch_valid <= 1'b0;
                    if (run) begin
                        state           <= FETCHING;
                        program_counter <= '0;
                        fault           <= 1'b0;
                        ran_off_end     <= 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator and run it from the project root
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps \
    --top-module compute_core_tb -f compute_core.f \
    --Mdir obj_dir -o compute_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build did not complete"
    exit 1
fi

./obj_dir/compute_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi
exit 0

// File: testbench/compute_core_checker.sv
// Done and fault rules at the core ports; concurrent assertions must be enabled in the simulator
`timescale 1ns/10ps

module compute_core_checker (
    input logic clock,
    input logic reset,
    input logic done,
    input logic fault
);

    // A run ends one way only
    exclusive_end: assert property (@(posedge clock) disable iff (reset) !(done && fault))
        else $error("done and fault are high together");

    done_single_cycle: assert property (@(posedge clock) disable iff (reset) done |=> !done)
        else $error("done stayed high for more than one cycle");

    quiet_after_reset: assert property (@(posedge clock) reset |=> (!done && !fault))
        else $error("done or fault is high in the cycle after reset");

endmodule

bind compute_core compute_core_checker port_checks (
    .clock(clock),
    .reset(reset),
    .done(done),
    .fault(fault)
);

// File: testbench/compute_core_tb.sv
// Directed and seeded random programs; the whole program store is reloaded before every run
`timescale 1ns/10ps

module compute_core_tb;
    import isa_pkg::*;
    import datapath_pkg::*;

    localparam int PROGRAM_DEPTH   = 64;
    localparam int ADDRESS_WIDTH   = $clog2(PROGRAM_DEPTH);
    localparam int CLOCK_PERIOD    = 8;
    localparam int RESET_CYCLES    = 4;
    localparam int RANDOM_PROGRAMS = 30;
    localparam int PROGRAM_COUNT   = 7 + RANDOM_PROGRAMS;
    // Store load, run and register readback of one program
    localparam int CYCLES_PER_PROGRAM = PROGRAM_DEPTH + (PROGRAM_DEPTH + 20) + REGISTER_COUNT;
    localparam int WATCHDOG_TIME =
        (RESET_CYCLES + PROGRAM_COUNT * CYCLES_PER_PROGRAM) * CLOCK_PERIOD;

    localparam int KIND_RUNNING = 0;
    localparam int KIND_DONE    = 1;
    localparam int KIND_FAULT   = 2;

    logic                     clock;
    logic                     reset;
    logic                     run;
    logic                     program_write;
    logic [ADDRESS_WIDTH-1:0] program_address;
    instruction_t             program_data;
    reg_index_t               debug_address;
    word_t                    debug_data;
    logic                     done;
    logic                     fault;

    word_t program_image [PROGRAM_DEPTH];
    int    program_length;
    word_t expected_registers [REGISTER_COUNT];
    // Handshake with the comparison process
    logic  compare_request;
    string compare_name;

    compute_core #(
        .PROGRAM_DEPTH(PROGRAM_DEPTH)
    ) dut (
        .clock(clock),
        .reset(reset),
        .run(run),
        .program_write(program_write),
        .program_address(program_address),
        .program_data(program_data),
        .debug_address(debug_address),
        .debug_data(debug_data),
        .done(done),
        .fault(fault)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    ////////////////////////////////////////
    // Program building
    ////////////////////////////////////////

    function automatic word_t register_format(input logic [4:0] opcode, input int dest,
                                              input int source_a, input int source_b);
        return {opcode, 4'(dest), 4'(source_a), 4'(source_b), 15'd0};
    endfunction

    function automatic word_t immediate_format(input logic [4:0] opcode, input int dest,
                                               input int source_a, input int immediate);
        return {opcode, 4'(dest), 4'(source_a), 19'(immediate)};
    endfunction

    function automatic void clear_program();
        for (int address = 0; address < PROGRAM_DEPTH; address++) begin
            program_image[address] = register_format(NOP, 0, 0, 0);
        end
        program_length = 0;
    endfunction

    function automatic void append_instruction(input word_t word);
        program_image[program_length] = word;
        program_length++;
    endfunction

    ////////////////////////////////////////
    // Reference interpreter
    ////////////////////////////////////////

    // Advances expected_registers through the program and returns how the run ends
    function automatic int interpret_program();
        word_t                             word;
        logic [4:0]                        opcode;
        reg_index_t                        dest;
        word_t                             a;
        word_t                             b;
        logic signed [IMMEDIATE_WIDTH-1:0] raw_immediate;
        word_t                             immediate;
        int                                pc;
        int                                kind;
        pc = 0;
        kind = KIND_RUNNING;
        while (kind == KIND_RUNNING) begin
            if (pc == PROGRAM_DEPTH) begin
                // Fetch ran past the last word without a STOP
                kind = KIND_FAULT;
            end else begin
                word = program_image[pc];
                opcode = word[31:27];
                dest = word[26:23];
                a = expected_registers[word[22:19]];
                b = expected_registers[word[18:15]];
                raw_immediate = word[18:0];
                immediate = word_t'(raw_immediate);
                case (opcode)
                    NOP: ;
                    ADD: expected_registers[dest] = a + b;
                    SUB: expected_registers[dest] = a - b;
                    AND: expected_registers[dest] = a & b;
                    OR: expected_registers[dest] = a | b;
                    XOR: expected_registers[dest] = a ^ b;
                    SHL: expected_registers[dest] = a << b[4:0];
                    SHR: expected_registers[dest] = a >> b[4:0];
                    SLT: expected_registers[dest] = ($signed(a) < $signed(b)) ? 1 : 0;
                    ADDI: expected_registers[dest] = a + immediate;
                    LDI: expected_registers[dest] = immediate;
                    STOP: kind = KIND_DONE;
                    default: kind = KIND_FAULT;
                endcase
                pc++;
            end
        end
        return kind;
    endfunction

    ////////////////////////////////////////
    // Driving and checking
    ////////////////////////////////////////

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic load_program();
        for (int address = 0; address < PROGRAM_DEPTH; address++) begin
            @(posedge clock);
            program_write   <= 1'b1;
            program_address <= ADDRESS_WIDTH'(address);
            program_data    <= program_image[address];
        end
        @(posedge clock);
        program_write <= 1'b0;
    endtask

    // A nonzero busy_run_delay pulses run again that many cycles into the program
    task automatic run_and_compare(input string name, input int busy_run_delay);
        int expected_kind;
        expected_kind = interpret_program();
        load_program();
        @(posedge clock);
        run <= 1'b1;
        @(posedge clock);
        run <= 1'b0;
        if (busy_run_delay > 0) begin
            repeat (busy_run_delay) @(posedge clock);
            run <= 1'b1;
            @(posedge clock);
            run <= 1'b0;
        end
        @(negedge clock);
        while (!done && !fault) @(negedge clock);
        check_value({name, " done"}, word_t'(expected_kind == KIND_DONE), word_t'(done));
        check_value({name, " fault"}, word_t'(expected_kind == KIND_FAULT), word_t'(fault));
        if (busy_run_delay > 0) begin
            repeat (20) begin
                @(negedge clock);
                check_value({name, " second done"}, '0, word_t'(done));
            end
        end
        compare_name = name;
        compare_request = 1'b1;
        wait (!compare_request);
    endtask

    // Reads back every register through the debug port
    always begin
        wait (compare_request);
        for (int i = 0; i < REGISTER_COUNT; i++) begin
            @(posedge clock);
            debug_address <= reg_index_t'(i);
            @(negedge clock);
            check_value($sformatf("%s r%0d", compare_name, i), expected_registers[i],
                        debug_data);
        end
        compare_request = 1'b0;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired before all programs had finished");
        $display("TESTS FAILED");
        $fatal(1, "Run took too long");
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        word_t word;
        void'($urandom(32'h1e96_1913));
        clock = 1'b0;
        reset = 1'b1;
        run = 1'b0;
        program_write = 1'b0;
        program_address = '0;
        program_data = '0;
        debug_address = '0;
        compare_request = 1'b0;
        expected_registers = '{default: '0};
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        // Every register-format opcode with a shift amount above 31
        clear_program();
        append_instruction(immediate_format(LDI, 1, 0, -5));
        append_instruction(immediate_format(LDI, 2, 0, 7));
        append_instruction(immediate_format(LDI, 3, 0, 37));
        append_instruction(immediate_format(LDI, 4, 0, 'h2_3456));
        append_instruction(register_format(ADD, 5, 1, 2));
        append_instruction(register_format(SUB, 6, 2, 1));
        append_instruction(register_format(AND, 7, 4, 1));
        append_instruction(register_format(OR, 8, 4, 2));
        append_instruction(register_format(XOR, 9, 4, 1));
        append_instruction(register_format(SHL, 10, 4, 3));
        append_instruction(register_format(SHR, 11, 1, 3));
        append_instruction(register_format(SLT, 12, 1, 2));
        append_instruction(register_format(SLT, 13, 2, 1));
        append_instruction(register_format(NOP, 5, 1, 1));
        append_instruction(register_format(STOP, 0, 0, 0));
        run_and_compare("register opcodes", 0);

        // Each result feeds the next instruction through the bypass
        clear_program();
        append_instruction(immediate_format(LDI, 1, 0, 3));
        append_instruction(register_format(ADD, 1, 1, 1));
        append_instruction(register_format(ADD, 2, 1, 1));
        append_instruction(register_format(SUB, 3, 2, 1));
        append_instruction(register_format(XOR, 1, 3, 2));
        append_instruction(immediate_format(ADDI, 1, 1, 100));
        append_instruction(register_format(SHL, 4, 2, 1));
        append_instruction(register_format(SLT, 5, 4, 1));
        append_instruction(register_format(STOP, 0, 0, 0));
        run_and_compare("dependent chain", 0);

        // Immediates at both ends of the 19-bit range
        clear_program();
        append_instruction(immediate_format(LDI, 1, 0, -1));
        append_instruction(immediate_format(LDI, 2, 0, 'h3_FFFF));
        append_instruction(immediate_format(LDI, 3, 0, -'h4_0000));
        append_instruction(immediate_format(ADDI, 4, 2, -3));
        append_instruction(immediate_format(ADDI, 5, 3, 'h100));
        append_instruction(immediate_format(ADDI, 6, 1, 1));
        append_instruction(immediate_format(ADDI, 7, 1, -'h4_0000));
        append_instruction(register_format(STOP, 0, 0, 0));
        run_and_compare("immediates", 0);

        // Opcode 12 is undefined so nothing from it onward may write
        clear_program();
        append_instruction(immediate_format(LDI, 14, 0, 11));
        append_instruction(immediate_format(ADDI, 14, 14, 1));
        append_instruction(register_format(5'd12, 14, 14, 14));
        append_instruction(immediate_format(LDI, 15, 0, 99));
        append_instruction(register_format(STOP, 0, 0, 0));
        run_and_compare("undefined opcode", 0);

        clear_program();
        for (int i = 0; i < PROGRAM_DEPTH; i++) begin
            append_instruction(immediate_format(ADDI, 0, 0, 1));
        end
        run_and_compare("no stop", 0);

        for (int n = 0; n < RANDOM_PROGRAMS; n++) begin
            clear_program();
            repeat ($urandom_range(1, 20)) begin
                word = $urandom;
                word[31:27] = 5'($urandom_range(0, 10));
                append_instruction(word);
            end
            append_instruction(register_format(STOP, 0, 0, 0));
            run_and_compare($sformatf("random program %0d", n), 0);
        end

        // Run pulse while busy and a second program on the registers left behind
        clear_program();
        append_instruction(immediate_format(ADDI, 1, 1, 1));
        append_instruction(immediate_format(ADDI, 2, 1, 2));
        append_instruction(register_format(ADD, 3, 1, 2));
        append_instruction(immediate_format(ADDI, 1, 1, 1));
        append_instruction(immediate_format(ADDI, 1, 1, 1));
        append_instruction(register_format(NOP, 0, 0, 0));
        append_instruction(register_format(NOP, 0, 0, 0));
        append_instruction(register_format(STOP, 0, 0, 0));
        run_and_compare("run while busy", 2);

        clear_program();
        append_instruction(register_format(ADD, 4, 1, 3));
        append_instruction(register_format(SUB, 5, 4, 2));
        append_instruction(register_format(STOP, 0, 0, 0));
        run_and_compare("second run", 0);

        $display("TESTS PASSED");
        $finish;
    end

endmodule
